/* build.f */
+incdir+rtl
rtl/game_pkg.sv
rtl/player_logic.sv
rtl/enemy_logic.sv
rtl/game_state_ctrl.sv
rtl/game_top.sv
verification/game_tb.sv

/* rtl/enemy_logic.sv */
// Steps toward target every GAME_ENEMY_PACE ticks; target must itself lie inside the grid
`timescale 1ns/10ps
`include "game_cfg.svh"

module enemy_logic (
    input  logic            clk,
    input  logic            reset,
    input  logic            play_tick,
    input  logic            respawn,
    input  game_pkg::cell_t target,
    output game_pkg::cell_t enemy_pos
);

    game_pkg::cell_t pos_q;
    logic [2:0]      pace_cnt;
    logic            step;
    logic [3:0]      x_next;
    logic [3:0]      y_next;

    assign step = play_tick && (pace_cnt == `GAME_ENEMY_PACE - 3'd1);

    // One cell toward the target, x first
    always_comb begin
        x_next = pos_q[7:4];
        y_next = pos_q[3:0];
        if (pos_q[7:4] != target[7:4]) begin
            if (pos_q[7:4] < target[7:4]) begin
                x_next = pos_q[7:4] + 4'd1;
            end else begin
                x_next = pos_q[7:4] - 4'd1;
            end
        end else if (pos_q[3:0] != target[3:0]) begin
            if (pos_q[3:0] < target[3:0]) begin
                y_next = pos_q[3:0] + 4'd1;
            end else begin
                y_next = pos_q[3:0] - 4'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            pos_q    <= `GAME_ENEMY_SPAWN;
            pace_cnt <= 3'd0;
        end else if (respawn) begin
            pos_q    <= `GAME_ENEMY_SPAWN;
            pace_cnt <= 3'd0;
        end else if (play_tick) begin
            if (step) begin
                pace_cnt <= 3'd0;
                pos_q    <= {x_next, y_next};    // Same cell when on target
            end else begin
                pace_cnt <= pace_cnt + 3'd1;
            end
        end
    end

    assign enemy_pos = pos_q;

    // Holds only while the target stays on the grid
    a_enemy_in_bounds: assert property (@(posedge clk) disable iff (!reset)
        pos_q[7:4] <= `GAME_X_MAX && pos_q[3:0] >= `GAME_Y_MIN && pos_q[3:0] <= `GAME_Y_MAX);

endmodule

/* rtl/game_cfg.svh */
// Grid is fixed at 16x12 with row 0 reserved; all counts are in frame ticks, keep widths as sized
`ifndef GAME_CFG_SVH
`define GAME_CFG_SVH

// Play-field limits, row 0 is left for the status bar
`define GAME_X_MAX          4'd15
`define GAME_Y_MIN          4'd1
`define GAME_Y_MAX          4'd11

// Spawn cells, x in high nibble, y in low nibble
`define GAME_PLAYER_SPAWN   8'h16
`define GAME_ENEMY_SPAWN    8'he6

// Sword swing length in ticks
`define GAME_ATTACK_FRAMES  3'd5

// Ticks per enemy step
`define GAME_ENEMY_PACE     3'd4

// Lives after reset
`define GAME_START_LIVES    2'd3

// Walk cycle, sprite 3 then sprite 2
`define GAME_ANIM_PERIOD    5'd21
`define GAME_ANIM_SWITCH    5'd8

// Sprite indices used by the walk cycle
`define GAME_SPRITE_STEP_A  4'd3
`define GAME_SPRITE_STEP_B  4'd2

`endif

/* rtl/game_pkg.sv */
// Shared game types only; cell_t packs x in the high nibble and y in the low nibble
package game_pkg;

    typedef logic [7:0] cell_t;    // {x, y}
    typedef logic [7:0] score_t;   // Enemies defeated, wraps
    typedef logic [1:0] lives_t;
    typedef logic [3:0] sprite_t;

    typedef enum logic [1:0] {
        DIR_UP    = 2'd0,
        DIR_RIGHT = 2'd1,
        DIR_DOWN  = 2'd2,
        DIR_LEFT  = 2'd3
    } dir_t;

    typedef enum logic {
        PS_IDLE,
        PS_ATTACK
    } player_state_t;

    // Pad buttons, held between frame ticks
    typedef struct packed {
        logic attack;
        logic up;
        logic down;
        logic left;
        logic right;
    } pad_t;

    typedef struct packed {
        cell_t   pos;
        dir_t    facing;
        sprite_t sprite;
    } player_view_t;

    typedef struct packed {
        logic  visible;
        cell_t pos;
        dir_t  dir;
    } sword_t;

endpackage

/* rtl/game_state_ctrl.sv */
// Judges on pre-tick positions; respawn pulses follow one cycle later, frame_end must be one cycle
`timescale 1ns/10ps
`include "game_cfg.svh"

module game_state_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   frame_end,
    input  game_pkg::player_view_t player,
    input  game_pkg::sword_t       sword,
    input  game_pkg::cell_t        enemy_pos,
    output logic                   play_tick,
    output logic                   player_respawn,
    output logic                   enemy_respawn,
    output game_pkg::score_t       score,
    output game_pkg::lives_t       lives,
    output logic                   game_over
);

    game_pkg::score_t score_q;
    game_pkg::lives_t lives_q;
    logic             game_over_q;
    logic             player_respawn_q;
    logic             enemy_respawn_q;
    logic             hit;
    logic             contact;

    assign play_tick = frame_end && !game_over_q;    // Play freezes at game over

    // A hit takes precedence over touching the player
    assign hit     = sword.visible && (sword.pos == enemy_pos);
    assign contact = !hit && (enemy_pos == player.pos);

    always_ff @(posedge clk) begin
        if (!reset) begin
            score_q     <= '0;
            lives_q     <= `GAME_START_LIVES;
            game_over_q <= 1'b0;
        end else if (play_tick) begin
            if (hit) begin
                score_q <= score_q + 8'd1;
            end else if (contact) begin
                lives_q <= lives_q - 2'd1;
                if (lives_q == 2'd1) begin
                    game_over_q <= 1'b1;    // Last life gone
                end
            end
        end
    end

    // Respawn orders land one cycle after the judging tick
    always_ff @(posedge clk) begin
        if (!reset) begin
            player_respawn_q <= 1'b0;
            enemy_respawn_q  <= 1'b0;
        end else begin
            player_respawn_q <= play_tick && contact;
            enemy_respawn_q  <= play_tick && (hit || contact);
        end
    end

    assign score          = score_q;
    assign lives          = lives_q;
    assign game_over      = game_over_q;
    assign player_respawn = player_respawn_q;
    assign enemy_respawn  = enemy_respawn_q;

    a_lives_never_rise: assert property (@(posedge clk) disable iff (!reset)
        1'b1 |=> lives_q <= $past(lives_q));

    a_player_respawn_pulse: assert property (@(posedge clk) disable iff (!reset)
        player_respawn_q |=> !player_respawn_q);

    a_enemy_respawn_pulse: assert property (@(posedge clk) disable iff (!reset)
        enemy_respawn_q |=> !enemy_respawn_q);

endmodule

/* rtl/game_top.sv */
// Play-field core only; frame_end comes from an external video timer, pad must be debounced
`timescale 1ns/10ps

module game_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   frame_end,
    input  game_pkg::pad_t         pad,
    output game_pkg::player_view_t player,
    output game_pkg::sword_t       sword,
    output game_pkg::cell_t        enemy_pos,
    output game_pkg::score_t       score,
    output game_pkg::lives_t       lives,
    output logic                   game_over
);

    logic play_tick;       // Gated frame tick
    logic player_respawn;
    logic enemy_respawn;

    player_logic i_player (
        .clk       (clk),
        .reset     (reset),
        .play_tick (play_tick),
        .pad       (pad),
        .respawn   (player_respawn),
        .player    (player),
        .sword     (sword)
    );

    // Enemy chases the player cell
    enemy_logic i_enemy (
        .clk       (clk),
        .reset     (reset),
        .play_tick (play_tick),
        .respawn   (enemy_respawn),
        .target    (player.pos),
        .enemy_pos (enemy_pos)
    );

    game_state_ctrl i_ctrl (
        .clk            (clk),
        .reset          (reset),
        .frame_end      (frame_end),
        .player         (player),
        .sword          (sword),
        .enemy_pos      (enemy_pos),
        .play_tick      (play_tick),
        .player_respawn (player_respawn),
        .enemy_respawn  (enemy_respawn),
        .score          (score),
        .lives          (lives),
        .game_over      (game_over)
    );

endmodule

/* rtl/player_logic.sv */
// Moves only on play_tick; respawn wins over a tick, sword cell may wrap past the grid edge
`timescale 1ns/10ps
`include "game_cfg.svh"

module player_logic (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  play_tick,
    input  game_pkg::pad_t        pad,
    input  logic                  respawn,
    output game_pkg::player_view_t player,
    output game_pkg::sword_t      sword
);

    game_pkg::player_state_t state_q;
    game_pkg::cell_t         pos_q;
    game_pkg::dir_t          facing_q;
    game_pkg::sword_t        sword_q;
    logic [2:0]              attack_cnt;    // Ticks spent in the swing
    logic [4:0]              anim_cnt;
    game_pkg::sprite_t       sprite;

    logic [3:0]              x_next;
    logic [3:0]              y_next;
    logic                    moved_h;
    logic                    moved_v;
    game_pkg::dir_t          facing_next;
    game_pkg::dir_t          swing_dir;

    // Cell next to c in direction d, nibbles wrap on their own
    function automatic game_pkg::cell_t neighbor(input game_pkg::cell_t c,
                                                 input game_pkg::dir_t d);
        game_pkg::cell_t n;
        case (d)
            game_pkg::DIR_UP:    n = {c[7:4], c[3:0] - 4'd1};
            game_pkg::DIR_DOWN:  n = {c[7:4], c[3:0] + 4'd1};
            game_pkg::DIR_LEFT:  n = {c[7:4] - 4'd1, c[3:0]};
            default:             n = {c[7:4] + 4'd1, c[3:0]};
        endcase
        return n;
    endfunction

    always_comb begin
        x_next      = pos_q[7:4];
        y_next      = pos_q[3:0];
        moved_h     = 1'b0;
        moved_v     = 1'b0;
        facing_next = facing_q;

        if (pad.down) begin                                  // Down beats up
            if (pos_q[3:0] < `GAME_Y_MAX) begin
                y_next  = pos_q[3:0] + 4'd1;
                moved_v = 1'b1;
            end
        end else if (pad.up && pos_q[3:0] > `GAME_Y_MIN) begin
            y_next  = pos_q[3:0] - 4'd1;
            moved_v = 1'b1;
        end

        if (pad.right) begin                                 // Right beats left
            if (pos_q[7:4] < `GAME_X_MAX) begin
                x_next  = pos_q[7:4] + 4'd1;
                moved_h = 1'b1;
            end
        end else if (pad.left && pos_q[7:4] > 4'd0) begin
            x_next  = pos_q[7:4] - 4'd1;
            moved_h = 1'b1;
        end

        // Horizontal move sets facing over a vertical one
        if (moved_h) begin
            facing_next = pad.right ? game_pkg::DIR_RIGHT : game_pkg::DIR_LEFT;
        end else if (moved_v) begin
            facing_next = pad.down ? game_pkg::DIR_DOWN : game_pkg::DIR_UP;
        end

        if (pad.right) begin
            swing_dir = game_pkg::DIR_RIGHT;
        end else if (pad.left) begin
            swing_dir = game_pkg::DIR_LEFT;
        end else if (pad.down) begin
            swing_dir = game_pkg::DIR_DOWN;
        end else if (pad.up) begin
            swing_dir = game_pkg::DIR_UP;
        end else begin
            swing_dir = facing_q;                            // No button, keep facing
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state_q    <= game_pkg::PS_IDLE;
            pos_q      <= `GAME_PLAYER_SPAWN;
            facing_q   <= game_pkg::DIR_RIGHT;
            sword_q    <= '0;
            attack_cnt <= 3'd0;
        end else if (respawn) begin
            state_q         <= game_pkg::PS_IDLE;
            pos_q           <= `GAME_PLAYER_SPAWN;
            sword_q.visible <= 1'b0;
            attack_cnt      <= 3'd0;
        end else if (play_tick) begin
            if (state_q == game_pkg::PS_IDLE) begin
                if (pad.attack) begin
                    state_q         <= game_pkg::PS_ATTACK;
                    attack_cnt      <= 3'd0;
                    sword_q.visible <= 1'b1;
                    sword_q.pos     <= neighbor(pos_q, swing_dir);
                    sword_q.dir     <= swing_dir;
                end else begin
                    pos_q    <= {x_next, y_next};
                    facing_q <= facing_next;
                end
            end else begin
                if (attack_cnt == `GAME_ATTACK_FRAMES - 3'd1) begin  // Last tick of the swing
                    state_q         <= game_pkg::PS_IDLE;
                    sword_q.visible <= 1'b0;
                end else begin
                    attack_cnt <= attack_cnt + 3'd1;
                end
            end
        end
    end

    // Walk cycle runs on every tick, also during a swing
    always_ff @(posedge clk) begin
        if (!reset) begin
            anim_cnt <= 5'd0;
        end else if (play_tick) begin
            if (anim_cnt == `GAME_ANIM_PERIOD - 5'd1) begin
                anim_cnt <= 5'd0;
            end else begin
                anim_cnt <= anim_cnt + 5'd1;
            end
        end
    end

    assign sprite = (anim_cnt < `GAME_ANIM_SWITCH) ? `GAME_SPRITE_STEP_A : `GAME_SPRITE_STEP_B;

    assign player = '{pos: pos_q, facing: facing_q, sprite: sprite};
    assign sword  = sword_q;

    a_player_in_bounds: assert property (@(posedge clk) disable iff (!reset)
        pos_q[7:4] <= `GAME_X_MAX && pos_q[3:0] >= `GAME_Y_MIN && pos_q[3:0] <= `GAME_Y_MAX);

    a_no_sword_in_idle: assert property (@(posedge clk) disable iff (!reset)
        state_q == game_pkg::PS_IDLE |-> !sword_q.visible);

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module game_tb -o game_sim \
    && ./obj_dir/game_sim | tee /dev/stderr | grep -q "SIMULATION PASSED" \
    && echo "Verilator run passed" \
    || { echo "Verilator run failed"; exit 1; }

/* verification/game_tb.sv */
// Stimulus on falling edges, one frame tick every 6 cycles; the run stops at the first mismatch
`timescale 1ns/10ps
`include "game_cfg.svh"

module game_tb;

    localparam int PLANNED_TICKS  = 200;
    localparam int TIMEOUT_CYCLES = 6 * PLANNED_TICKS + 100;
    localparam int CONTACT_WAIT   = 20;    // Ticks allowed per contact

    logic                   clk;
    logic                   reset;
    logic                   frame_end;
    game_pkg::pad_t         pad;
    game_pkg::player_view_t player;
    game_pkg::sword_t       sword;
    game_pkg::cell_t        enemy_pos;
    game_pkg::score_t       score;
    game_pkg::lives_t       lives;
    logic                   game_over;

    int seed      = 32'hec18;
    int cycle_cnt = 0;

    // Reference model of the game rules
    game_pkg::cell_t m_ppos;
    game_pkg::dir_t  m_facing;
    logic            m_attack;
    int              m_att_cnt;
    int              m_anim;
    logic            m_sw_vis;
    game_pkg::cell_t m_sw_pos;
    game_pkg::dir_t  m_sw_dir;
    game_pkg::cell_t m_epos;
    int              m_pace;
    logic [7:0]      m_score;
    int              m_lives;
    logic            m_over;

    game_top i_dut (
        .clk       (clk),
        .reset     (reset),
        .frame_end (frame_end),
        .pad       (pad),
        .player    (player),
        .sword     (sword),
        .enemy_pos (enemy_pos),
        .score     (score),
        .lives     (lives),
        .game_over (game_over)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES)
            fail_run("The run hung and reached the cycle limit");
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
            fail_run($sformatf("FAILED %s: got 0x%0h, expected 0x%0h",
                               name, actual, expected));
    endtask

    function automatic game_pkg::pad_t make_pad(input logic a, input logic u, input logic d,
                                                input logic l, input logic r);
        return {a, u, d, l, r};
    endfunction

    function automatic game_pkg::cell_t adjacent_cell(input game_pkg::cell_t c,
                                                      input game_pkg::dir_t d);
        logic [3:0] x;
        logic [3:0] y;
        x = c[7:4];
        y = c[3:0];
        if (d == game_pkg::DIR_UP) y = y - 4'd1;
        else if (d == game_pkg::DIR_DOWN) y = y + 4'd1;
        else if (d == game_pkg::DIR_LEFT) x = x - 4'd1;
        else x = x + 4'd1;
        return {x, y};
    endfunction

    // One cell toward the target, x before y
    function automatic game_pkg::cell_t step_toward(input game_pkg::cell_t from,
                                                    input game_pkg::cell_t to);
        logic [3:0] x;
        logic [3:0] y;
        x = from[7:4];
        y = from[3:0];
        if (x < to[7:4]) x = x + 4'd1;
        else if (x > to[7:4]) x = x - 4'd1;
        else if (y < to[3:0]) y = y + 4'd1;
        else if (y > to[3:0]) y = y - 4'd1;
        return {x, y};
    endfunction

    task automatic model_reset();
        m_ppos    = `GAME_PLAYER_SPAWN;
        m_facing  = game_pkg::DIR_RIGHT;
        m_attack  = 1'b0;
        m_att_cnt = 0;
        m_anim    = 0;
        m_sw_vis  = 1'b0;
        m_epos    = `GAME_ENEMY_SPAWN;
        m_pace    = 0;
        m_score   = 8'd0;
        m_lives   = `GAME_START_LIVES;
        m_over    = 1'b0;
    endtask

    task automatic model_tick(input game_pkg::pad_t p);
        logic           hit;
        logic           contact;
        logic [3:0]     x;
        logic [3:0]     y;
        logic           moved_x;
        logic           moved_y;
        game_pkg::dir_t d;
        if (m_over) return;                                  // Play is frozen
        hit     = m_sw_vis && (m_sw_pos == m_epos);           // Judged on pre-tick cells
        contact = !hit && (m_epos == m_ppos);
        if (m_pace == `GAME_ENEMY_PACE - 1) begin
            m_pace = 0;
            m_epos = step_toward(m_epos, m_ppos);
        end else begin
            m_pace++;
        end
        if (m_attack) begin
            if (m_att_cnt == `GAME_ATTACK_FRAMES - 1) begin
                m_attack = 1'b0;
                m_sw_vis = 1'b0;
            end else begin
                m_att_cnt++;
            end
        end else if (p.attack) begin
            if (p.right) d = game_pkg::DIR_RIGHT;
            else if (p.left) d = game_pkg::DIR_LEFT;
            else if (p.down) d = game_pkg::DIR_DOWN;
            else if (p.up) d = game_pkg::DIR_UP;
            else d = m_facing;
            m_attack  = 1'b1;
            m_att_cnt = 0;
            m_sw_vis  = 1'b1;
            m_sw_dir  = d;
            m_sw_pos  = adjacent_cell(m_ppos, d);
        end else begin
            x       = m_ppos[7:4];
            y       = m_ppos[3:0];
            moved_x = 1'b0;
            moved_y = 1'b0;
            if (p.down) begin
                if (y < `GAME_Y_MAX) begin
                    y       = y + 4'd1;
                    moved_y = 1'b1;
                end
            end else if (p.up && y > `GAME_Y_MIN) begin
                y       = y - 4'd1;
                moved_y = 1'b1;
            end
            if (p.right) begin
                if (x < `GAME_X_MAX) begin
                    x       = x + 4'd1;
                    moved_x = 1'b1;
                end
            end else if (p.left && x > 4'd0) begin
                x       = x - 4'd1;
                moved_x = 1'b1;
            end
            if (moved_x) m_facing = p.right ? game_pkg::DIR_RIGHT : game_pkg::DIR_LEFT;
            else if (moved_y) m_facing = p.down ? game_pkg::DIR_DOWN : game_pkg::DIR_UP;
            m_ppos = {x, y};
        end
        m_anim = (m_anim == `GAME_ANIM_PERIOD - 1) ? 0 : m_anim + 1;
        if (hit) begin
            m_score = m_score + 8'd1;
            m_epos  = `GAME_ENEMY_SPAWN;
            m_pace  = 0;
        end else if (contact) begin
            m_lives--;
            if (m_lives == 0) m_over = 1'b1;
            m_ppos   = `GAME_PLAYER_SPAWN;                    // Both sides respawn
            m_attack = 1'b0;
            m_sw_vis = 1'b0;
            m_epos   = `GAME_ENEMY_SPAWN;
            m_pace   = 0;
        end
    endtask

    task automatic check_outputs();
        check_value("player.pos", player.pos, m_ppos);
        check_value("player.facing", player.facing, m_facing);
        check_value("player.sprite", player.sprite, (m_anim < `GAME_ANIM_SWITCH) ? 3 : 2);
        check_value("sword.visible", sword.visible, m_sw_vis);
        if (m_sw_vis) begin
            check_value("sword.pos", sword.pos, m_sw_pos);
            check_value("sword.dir", sword.dir, m_sw_dir);
        end
        check_value("enemy_pos", enemy_pos, m_epos);
        check_value("score", score, m_score);
        check_value("lives", lives, m_lives);
        check_value("game_over", game_over, m_over);
    endtask

    task automatic apply_reset();
        reset     = 1'b0;
        frame_end = 1'b0;
        pad       = '0;
        repeat (3) @(negedge clk);
        reset = 1'b1;
        model_reset();
        @(negedge clk);
    endtask

    // One frame pulse, then settle before the next tick
    task automatic frame_tick(input game_pkg::pad_t p);
        pad       = p;
        frame_end = 1'b1;
        @(negedge clk);
        frame_end = 1'b0;
        model_tick(p);
        repeat (5) @(negedge clk);
        check_outputs();
    endtask

    task automatic test_after_reset();
        apply_reset();
        check_value("player.pos", player.pos, `GAME_PLAYER_SPAWN);
        check_value("enemy_pos", enemy_pos, `GAME_ENEMY_SPAWN);
        check_outputs();
    endtask

    task automatic test_movement();
        logic [31:0] rnd;
        apply_reset();
        repeat (7) frame_tick(make_pad(0, 1, 0, 0, 0));
        check_value("player.y at top", player.pos[3:0], `GAME_Y_MIN);
        repeat (3) frame_tick(make_pad(0, 0, 0, 1, 0));
        check_value("player.x at left", player.pos[7:4], 4'd0);
        repeat (12) frame_tick(make_pad(0, 0, 1, 0, 0));
        check_value("player.y at bottom", player.pos[3:0], `GAME_Y_MAX);
        repeat (17) frame_tick(make_pad(0, 0, 0, 0, 1));
        check_value("player.x at right", player.pos[7:4], `GAME_X_MAX);
        frame_tick(make_pad(0, 1, 1, 1, 0));                 // Down wins but is blocked
        check_value("player.pos", player.pos, 8'heb);
        frame_tick(make_pad(0, 1, 0, 0, 1));                 // Diagonal, facing goes horizontal
        check_value("player.facing", player.facing, game_pkg::DIR_RIGHT);
        repeat (40) begin
            rnd = $random(seed);
            frame_tick(rnd[4:0]);
        end
    endtask

    task automatic test_attack();
        int vis_ticks;
        apply_reset();
        vis_ticks = 0;
        frame_tick(make_pad(1, 0, 0, 0, 0));                 // Swing along held facing
        check_value("sword.pos", sword.pos, 8'h26);
        if (sword.visible) vis_ticks++;
        repeat (5) begin
            frame_tick(make_pad(0, 0, 0, 0, 1));
            if (sword.visible) vis_ticks++;
            check_value("player.pos in swing", player.pos, `GAME_PLAYER_SPAWN);
        end
        check_value("sword visible ticks", vis_ticks, `GAME_ATTACK_FRAMES);
        frame_tick(make_pad(1, 1, 0, 0, 0));                 // Pressed direction wins
        check_value("sword.pos", sword.pos, 8'h15);
        check_value("sword.dir", sword.dir, game_pkg::DIR_UP);
        repeat (5) frame_tick(make_pad(0, 0, 0, 0, 0));
    endtask

    task automatic test_chase();
        game_pkg::cell_t path[4];
        int              i;
        path = '{8'ha6, 8'ha5, 8'ha4, 8'ha3};
        apply_reset();
        repeat (9) frame_tick(make_pad(0, 0, 0, 0, 1));
        repeat (3) frame_tick(make_pad(0, 1, 0, 0, 0));
        check_value("enemy_pos", enemy_pos, 8'hb6);
        for (i = 0; i < 4; i++) begin
            repeat (4) frame_tick(make_pad(0, 0, 0, 0, 0));
            check_value("enemy_pos on path", enemy_pos, path[i]);
        end
    endtask

    task automatic test_hit();
        apply_reset();
        repeat (9) frame_tick(make_pad(0, 0, 0, 0, 1));
        repeat (3) frame_tick(make_pad(0, 0, 0, 0, 0));
        check_value("enemy_pos adjacent", enemy_pos, 8'hb6);
        frame_tick(make_pad(1, 0, 0, 0, 0));
        frame_tick(make_pad(0, 0, 0, 0, 0));                 // Sword meets the enemy
        check_value("score", score, 8'd1);
        check_value("enemy_pos respawned", enemy_pos, `GAME_ENEMY_SPAWN);
    endtask

    task automatic test_contact();
        int                     life;
        int                     waited;
        logic [31:0]            rnd;
        game_pkg::player_view_t held_player;
        game_pkg::cell_t        held_enemy;
        apply_reset();
        for (life = 1; life <= 3; life++) begin
            waited = 0;
            while (lives != `GAME_START_LIVES - life) begin
                if (waited == CONTACT_WAIT) begin
                    fail_run("The enemy never reached the player");
                end else begin
                    frame_tick(make_pad(0, 0, 0, 0, 1));
                    waited++;
                end
            end
            check_value("player.pos respawned", player.pos, `GAME_PLAYER_SPAWN);
            check_value("enemy_pos respawned", enemy_pos, `GAME_ENEMY_SPAWN);
        end
        check_value("game_over", game_over, 1'b1);
        held_player = player;
        held_enemy  = enemy_pos;
        repeat (5) begin
            rnd = $random(seed);
            frame_tick(rnd[4:0]);
            check_value("player after game over", player, held_player);
            check_value("enemy_pos after game over", enemy_pos, held_enemy);
        end
    endtask

    initial begin
        test_after_reset();
        test_movement();
        test_attack();
        test_chase();
        test_hit();
        test_contact();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
